// ==== logic/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

   localparam int xlen      = 32;
   localparam int reg_count = 32;

   // RV32I major opcodes
   localparam logic [6:0] op_lui    = 7'b0110111;
   localparam logic [6:0] op_auipc  = 7'b0010111;
   localparam logic [6:0] op_jal    = 7'b1101111;
   localparam logic [6:0] op_jalr   = 7'b1100111;
   localparam logic [6:0] op_branch = 7'b1100011;
   localparam logic [6:0] op_load   = 7'b0000011;
   localparam logic [6:0] op_store  = 7'b0100011;
   localparam logic [6:0] op_imm    = 7'b0010011;
   localparam logic [6:0] op_reg    = 7'b0110011;

   typedef enum logic [2:0] {
      imm_none,
      imm_i,
      imm_s,
      imm_b,
      imm_u,
      imm_j
   } imm_enc_e;

   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_sll,
      alu_slt,
      alu_sltu,
      alu_xor,
      alu_srl,
      alu_sra,
      alu_or,
      alu_and,
      alu_pass_b      // operand b straight through, used by lui
   } alu_op_e;

   typedef struct packed {
      alu_op_e  alu_op;
      imm_enc_e encoding;
      logic     alu_src_imm;  // operand b is the immediate
      logic     reg_write;
      logic     mem_read;
      logic     mem_write;
      logic     is_branch;
      logic     is_jump;
      logic     illegal;
   } control_t;

   typedef struct packed {
      logic            taken;
      logic [xlen-1:0] target;
   } branch_pred_t;

   function automatic logic [xlen-1:0] imm_extend(
      input logic [31:0] instr,
      input imm_enc_e    enc
   );
      logic [xlen-1:0] imm;
      case (enc)
         imm_i: begin
            imm = {{20{instr[31]}}, instr[31:20]};
         end
         imm_s: begin
            imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
         end
         imm_b: begin
            imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                   instr[11:8], 1'b0};
         end
         imm_u: begin
            imm = {instr[31:12], 12'h000};
         end
         imm_j: begin
            imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                   instr[30:21], 1'b0};
         end
         default: begin
            imm = '0;  // no immediate
         end
      endcase
      return imm;
   endfunction

endpackage

`default_nettype wire

// ==== logic/rv_decompress.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_decompress (
   input  logic [15:0] c_instr,
   output logic [31:0] expanded,
   output logic        c_illegal
);

   import rv_decode_pkg::*;

   logic [1:0]  quadrant;
   logic [2:0]  funct3;
   logic [4:0]  rd_full;
   logic [4:0]  rs2_full;
   logic [4:0]  reg_p_lo;   // rd' or rs2', bits 4:2
   logic [4:0]  reg_p_hi;   // rs1', bits 9:7
   logic [11:0] imm6;
   logic [6:0]  lw_off;
   logic [20:0] j_imm;
   logic [12:0] b_imm;

   assign quadrant = c_instr[1:0];
   assign funct3   = c_instr[15:13];
   assign rd_full  = c_instr[11:7];
   assign rs2_full = c_instr[6:2];
   assign reg_p_lo = {2'b01, c_instr[4:2]};   // x8..x15
   assign reg_p_hi = {2'b01, c_instr[9:7]};

   assign imm6   = {{6{c_instr[12]}}, c_instr[12], c_instr[6:2]};
   assign lw_off = {c_instr[5], c_instr[12:10], c_instr[6], 2'b00};   // word scaled

   assign j_imm = {{9{c_instr[12]}}, c_instr[12], c_instr[8], c_instr[10:9],
                   c_instr[6], c_instr[7], c_instr[2], c_instr[11],
                   c_instr[5:3], 1'b0};

   assign b_imm = {{4{c_instr[12]}}, c_instr[12], c_instr[6:5], c_instr[2],
                   c_instr[11:10], c_instr[4:3], 1'b0};

   always_comb begin
      expanded  = '0;
      c_illegal = (c_instr == 16'h0000);
      case ({quadrant, funct3})
         5'b00_010: begin  // c.lw
            expanded = {5'b00000, lw_off, reg_p_hi, 3'b010, reg_p_lo, op_load};
         end
         5'b00_110: begin  // c.sw
            expanded = {5'b00000, lw_off[6:5], reg_p_lo, reg_p_hi, 3'b010,
                        lw_off[4:0], op_store};
         end
         5'b01_000: begin  // c.addi
            expanded = {imm6, rd_full, 3'b000, rd_full, op_imm};
         end
         5'b01_010: begin  // c.li
            expanded = {imm6, 5'd0, 3'b000, rd_full, op_imm};
         end
         5'b01_011: begin
            // rd of 2 is c.addi16sp, zero immediate is reserved
            if (rd_full == 5'd2 || imm6[5:0] == 6'd0) begin
               c_illegal = 1'b1;
            end else begin
               expanded = {{14{c_instr[12]}}, c_instr[12], c_instr[6:2], rd_full, op_lui};
            end
         end
         5'b01_101: begin  // c.j
            expanded = {j_imm[20], j_imm[10:1], j_imm[11], j_imm[19:12], 5'd0, op_jal};
         end
         5'b01_110, 5'b01_111: begin  // c.beqz / c.bnez, funct3 bit 0 picks bne
            expanded = {b_imm[12], b_imm[10:5], 5'd0, reg_p_hi, 2'b00, funct3[0],
                        b_imm[4:1], b_imm[11], op_branch};
         end
         5'b10_100: begin
            if (rs2_full == 5'd0) begin
               c_illegal = 1'b1;   // c.jr, c.jalr, c.ebreak
            end else if (!c_instr[12]) begin
               expanded = {7'b0000000, rs2_full, 5'd0, 3'b000, rd_full, op_reg};
            end else begin
               expanded = {7'b0000000, rs2_full, rd_full, 3'b000, rd_full, op_reg};
            end
         end
         default: begin
            c_illegal = 1'b1;
         end
      endcase
      if (c_illegal) begin
         expanded = '0;
      end
   end

endmodule

`default_nettype wire

// ==== logic/rv_register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_register_file (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     write_en,
   input  logic [4:0]               write_id,
   input  logic [rv_decode_pkg::xlen-1:0] write_data,
   input  logic [4:0]               read1_id,
   input  logic [4:0]               read2_id,
   output logic [rv_decode_pkg::xlen-1:0] read1_data,
   output logic [rv_decode_pkg::xlen-1:0] read2_data,
   output logic [rv_decode_pkg::xlen-1:0] debug_reg [0:rv_decode_pkg::reg_count-1]
);

   import rv_decode_pkg::*;

   logic [xlen-1:0] regs [0:reg_count-1];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (write_en && write_id != 5'd0) begin  // x0 stays zero
         regs[write_id] <= write_data;
      end
   end

   assign read1_data = regs[read1_id];
   assign read2_data = regs[read2_id];
   assign debug_reg  = regs;

endmodule

`default_nettype wire

// ==== logic/rv_control_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_control_unit (
   input  logic [31:0]             instr,
   output rv_decode_pkg::control_t control
);

   import rv_decode_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       bad;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   always_comb begin
      control = '0;
      bad     = 1'b0;
      case (opcode)
         op_lui: begin
            control.alu_op      = alu_pass_b;
            control.encoding    = imm_u;
            control.alu_src_imm = 1'b1;
            control.reg_write   = 1'b1;
         end
         op_auipc: begin
            control.alu_op      = alu_add;
            control.encoding    = imm_u;
            control.alu_src_imm = 1'b1;
            control.reg_write   = 1'b1;
         end
         op_jal, op_jalr: begin
            control.alu_op      = alu_add;
            control.encoding    = (opcode == op_jal) ? imm_j : imm_i;
            control.alu_src_imm = 1'b1;
            control.reg_write   = 1'b1;
            control.is_jump     = 1'b1;
            bad = (opcode == op_jalr) && (funct3 != 3'b000);
         end
         op_branch: begin
            control.alu_op    = alu_sub;   // compare by subtraction
            control.encoding  = imm_b;
            control.is_branch = 1'b1;
            bad = (funct3 == 3'b010) || (funct3 == 3'b011);
         end
         op_load, op_store: begin
            control.alu_op      = alu_add;   // base + offset
            control.encoding    = (opcode == op_load) ? imm_i : imm_s;
            control.alu_src_imm = 1'b1;
            control.reg_write   = (opcode == op_load);
            control.mem_read    = (opcode == op_load);
            control.mem_write   = (opcode == op_store);
            bad = (funct3 != 3'b010);   // word access only
         end
         op_imm, op_reg: begin
            control.encoding    = (opcode == op_imm) ? imm_i : imm_none;
            control.alu_src_imm = (opcode == op_imm);
            control.reg_write   = 1'b1;
            case (funct3)
               3'b000: control.alu_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
               3'b001: control.alu_op = alu_sll;
               3'b010: control.alu_op = alu_slt;
               3'b011: control.alu_op = alu_sltu;
               3'b100: control.alu_op = alu_xor;
               3'b101: control.alu_op = funct7[5] ? alu_sra : alu_srl;
               3'b110: control.alu_op = alu_or;
               default: control.alu_op = alu_and;
            endcase
            // addi-type immediates own funct7, shifts and reg ops do not
            if (opcode == op_reg || funct3 == 3'b001 || funct3 == 3'b101) begin
               if (funct7 == 7'b0100000) begin
                  bad = !(funct3 == 3'b101 || (funct3 == 3'b000 && opcode == op_reg));
               end else begin
                  bad = (funct7 != 7'b0000000);
               end
            end
         end
         default: begin
            bad = 1'b1;
         end
      endcase
      if (bad) begin
         control         = '0;
         control.illegal = 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage #(
   parameter bit rvc_en = 1'b1
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic [31:0]                        instruction,
   input  logic [rv_decode_pkg::xlen-1:0]     pc,
   input  rv_decode_pkg::branch_pred_t        branch_in,
   input  logic                               write_en,
   input  logic [4:0]                         write_id,
   input  logic [rv_decode_pkg::xlen-1:0]     write_data,
   output rv_decode_pkg::branch_pred_t        branch_out,
   output logic [rv_decode_pkg::xlen-1:0]     pc_out,
   output logic [4:0]                         reg_rd_id,
   output logic [rv_decode_pkg::xlen-1:0]     read_data1,
   output logic [rv_decode_pkg::xlen-1:0]     read_data2,
   output logic [rv_decode_pkg::xlen-1:0]     immediate_data,
   output rv_decode_pkg::control_t            control_signals,
   output logic [rv_decode_pkg::xlen-1:0]     debug_reg [0:rv_decode_pkg::reg_count-1]
);

   import rv_decode_pkg::*;

   logic        is_compressed;
   logic [31:0] expanded;
   logic        c_illegal;
   logic [31:0] eff_instr;
   control_t    base_ctl;

   assign is_compressed = (instruction[1:0] != 2'b11);

   generate
      if (rvc_en) begin : g_rvc
         rv_decompress u_decompress (
            .c_instr   (instruction[15:0]),
            .expanded  (expanded),
            .c_illegal (c_illegal)
         );
      end else begin : g_no_rvc
         assign expanded  = '0;
         assign c_illegal = 1'b1;   // every compressed word rejected
      end
   endgenerate

   assign eff_instr = is_compressed ? expanded : instruction;

   rv_register_file u_regfile (
      .clk        (clk),
      .rst_n      (rst_n),
      .write_en   (write_en),
      .write_id   (write_id),
      .write_data (write_data),
      .read1_id   (eff_instr[19:15]),
      .read2_id   (eff_instr[24:20]),
      .read1_data (read_data1),
      .read2_data (read_data2),
      .debug_reg  (debug_reg)
   );

   rv_control_unit u_control (
      .instr   (eff_instr),
      .control (base_ctl)
   );

   always_comb begin
      control_signals = base_ctl;
      if (is_compressed && c_illegal) begin
         control_signals.illegal   = 1'b1;
         control_signals.reg_write = 1'b0;
         control_signals.mem_read  = 1'b0;
         control_signals.mem_write = 1'b0;
         control_signals.is_branch = 1'b0;
         control_signals.is_jump   = 1'b0;
      end
   end

   assign reg_rd_id      = eff_instr[11:7];
   assign immediate_data = imm_extend(eff_instr, control_signals.encoding);
   assign pc_out         = pc;
   assign branch_out     = branch_in;

endmodule

`default_nettype wire

// ==== sim/decode_stage_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage_sva (
   input logic                           clk,
   input logic                           rst_n,
   input logic [rv_decode_pkg::xlen-1:0] pc,
   input logic [rv_decode_pkg::xlen-1:0] pc_out,
   input logic [rv_decode_pkg::xlen-1:0] x0_value,
   input rv_decode_pkg::control_t        control_signals
);

   import rv_decode_pkg::*;

   a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n) x0_value == '0)
      else $error("register x0 holds a nonzero value");

   a_pc_pass: assert property (@(posedge clk) disable iff (!rst_n) pc_out == pc)
      else $error("pc_out differs from pc");

   a_illegal_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      control_signals.illegal |-> !(control_signals.reg_write || control_signals.mem_read ||
                                    control_signals.mem_write))
      else $error("illegal instruction with an enable set");

   a_branch_jump: assert property (@(posedge clk) disable iff (!rst_n)
      !(control_signals.is_branch && control_signals.is_jump))
      else $error("branch and jump both set");

endmodule

bind decode_stage decode_stage_sva u_sva (
   .clk             (clk),
   .rst_n           (rst_n),
   .pc              (pc),
   .pc_out          (pc_out),
   .x0_value        (debug_reg[0]),
   .control_signals (control_signals)
);

`default_nettype wire

// ==== sim/decode_stage_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage_tb;

   import rv_decode_pkg::*;

   logic            clk;
   logic            rst_n;
   logic [31:0]     instruction;
   logic [xlen-1:0] pc;
   branch_pred_t    branch_in;
   logic            write_en;
   logic [4:0]      write_id;
   logic [xlen-1:0] write_data;
   branch_pred_t    branch_out;
   logic [xlen-1:0] pc_out;
   logic [4:0]      reg_rd_id;
   logic [xlen-1:0] read_data1;
   logic [xlen-1:0] read_data2;
   logic [xlen-1:0] immediate_data;
   control_t        control_signals;
   logic [xlen-1:0] debug_reg [0:reg_count-1];

   logic [xlen-1:0] model_regs [0:reg_count-1];
   integer          seed;
   string           cur_test;
   int              checks;
   int              errors;
   int              test_checks;
   int              test_errs;
   int              pt_checks;
   int              pt_errs;

   decode_stage #(
      .rvc_en (1'b1)
   ) u_dut (
      .clk             (clk),
      .rst_n           (rst_n),
      .instruction     (instruction),
      .pc              (pc),
      .branch_in       (branch_in),
      .write_en        (write_en),
      .write_id        (write_id),
      .write_data      (write_data),
      .branch_out      (branch_out),
      .pc_out          (pc_out),
      .reg_rd_id       (reg_rd_id),
      .read_data1      (read_data1),
      .read_data2      (read_data2),
      .immediate_data  (immediate_data),
      .control_signals (control_signals),
      .debug_reg       (debug_reg)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
   end

   initial begin
      #100000;
      $display("timeout: simulation did not finish in time");
      $display("RESULT: FAIL");
      $finish;
   end

   function automatic logic [31:0] ref_imm(input logic [31:0] w, input imm_enc_e enc);
      logic signed [31:0] v;
      case (enc)
         imm_i: v = $signed(w[31:20]);
         imm_s: v = $signed({w[31:25], w[11:7]});
         imm_b: v = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
         imm_u: v = {w[31:12], 12'd0};
         imm_j: v = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
         default: v = 0;
      endcase
      return v;
   endfunction

   function automatic control_t ref_control(input logic [31:0] w);
      control_t   c;
      logic [6:0] op;
      logic [2:0] f3;
      logic [6:0] f7;
      logic       ok;
      logic       f7_live;
      op = w[6:0];
      f3 = w[14:12];
      f7 = w[31:25];
      ok = 1'b1;
      c = '0;
      c.alu_op = alu_add;
      c.alu_src_imm = 1'b1;
      c.reg_write = 1'b1;
      case (op)
         op_lui: begin
            c.alu_op = alu_pass_b;
            c.encoding = imm_u;
         end
         op_auipc: c.encoding = imm_u;
         op_jal: begin
            c.encoding = imm_j;
            c.is_jump = 1'b1;
         end
         op_jalr: begin
            c.encoding = imm_i;
            c.is_jump = 1'b1;
            ok = (f3 == 3'b000);
         end
         op_branch: begin
            c.alu_op = alu_sub;
            c.encoding = imm_b;
            c.alu_src_imm = 1'b0;
            c.reg_write = 1'b0;
            c.is_branch = 1'b1;
            ok = (f3[2:1] != 2'b01);
         end
         op_load: begin
            c.encoding = imm_i;
            c.mem_read = 1'b1;
            ok = (f3 == 3'b010);
         end
         op_store: begin
            c.encoding = imm_s;
            c.reg_write = 1'b0;
            c.mem_write = 1'b1;
            ok = (f3 == 3'b010);
         end
         op_imm, op_reg: begin
            f7_live = (op == op_reg) || (f3[1:0] == 2'b01);   // shifts and register ops
            c.encoding = (op == op_imm) ? imm_i : imm_none;
            c.alu_src_imm = (op == op_imm);
            case (f3)
               3'b000: c.alu_op = (op == op_reg && f7 == 7'b0100000) ? alu_sub : alu_add;
               3'b001: c.alu_op = alu_sll;
               3'b010: c.alu_op = alu_slt;
               3'b011: c.alu_op = alu_sltu;
               3'b100: c.alu_op = alu_xor;
               3'b101: c.alu_op = (f7 == 7'b0100000) ? alu_sra : alu_srl;
               3'b110: c.alu_op = alu_or;
               default: c.alu_op = alu_and;
            endcase
            ok = !f7_live || f7 == 7'd0 ||
                 (f7 == 7'b0100000 && (f3 == 3'b101 || (op == op_reg && f3 == 3'b000)));
         end
         default: ok = 1'b0;
      endcase
      if (!ok) begin
         c = '0;
         c.illegal = 1'b1;
      end
      return c;
   endfunction

   // returns {illegal, 32-bit equivalent}
   function automatic logic [32:0] ref_expand(input logic [15:0] c);
      logic [31:0]        w;
      logic               bad;
      logic [4:0]         rd;
      logic [4:0]         rs2;
      logic [4:0]         rp_lo;
      logic [4:0]         rp_hi;
      logic signed [31:0] imm;
      logic signed [31:0] off;
      w = '0;
      bad = 1'b0;
      rd = c[11:7];
      rs2 = c[6:2];
      rp_lo = 5'd8 + c[4:2];
      rp_hi = 5'd8 + c[9:7];
      imm = $signed({c[12], c[6:2]});
      off = {c[5], c[12:10], c[6], 2'b00};   // c.lw / c.sw offset
      case ({c[1:0], c[15:13]})
         5'b00_010: w = {off[11:0], rp_hi, 3'b010, rp_lo, op_load};
         5'b00_110: w = {off[11:5], rp_lo, rp_hi, 3'b010, off[4:0], op_store};
         5'b01_000: w = {imm[11:0], rd, 3'b000, rd, op_imm};
         5'b01_010: w = {imm[11:0], 5'd0, 3'b000, rd, op_imm};
         5'b01_011: begin
            bad = (rd == 5'd2) || (imm == 0);
            w = {imm[19:0], rd, op_lui};
         end
         5'b01_101: begin
            off = $signed({c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0});
            w = {off[20], off[10:1], off[11], off[19:12], 5'd0, op_jal};
         end
         5'b01_110, 5'b01_111: begin
            off = $signed({c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0});
            w = {off[12], off[10:5], 5'd0, rp_hi, 2'b00, c[13], off[4:1], off[11], op_branch};
         end
         5'b10_100: begin
            bad = (rs2 == 5'd0);
            w = {7'd0, rs2, c[12] ? rd : 5'd0, 3'b000, rd, op_reg};   // c.add or c.mv
         end
         default: bad = 1'b1;
      endcase
      if (c == 16'h0000) bad = 1'b1;
      if (bad) w = '0;
      return {bad, w};
   endfunction

   task automatic start_test(input string name);
      cur_test = name;
      test_checks = 0;
      test_errs = 0;
   endtask

   task automatic end_test();
      $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errs);
   endtask

   task automatic expect_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
      checks++;
      test_checks++;
      if (exp !== act) begin
         errors++;
         test_errs++;
         $display("ERR %s %s expected %h actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic drive_and_check(input logic [31:0] instr, input logic we, input logic [4:0] wid,
                                  input logic [31:0] wdata, input logic must_be_illegal);
      logic [32:0]  ex;
      logic [31:0]  eff;
      control_t     exp_c;
      logic [31:0]  exp_pc;
      branch_pred_t exp_br;
      logic [31:0]  rnd;
      @(posedge clk);
      #1;
      instruction = instr;
      write_en = we;
      write_id = wid;
      write_data = wdata;
      exp_pc = $random(seed);
      rnd = $random(seed);
      exp_br.taken = rnd[0];
      exp_br.target = $random(seed);
      pc = exp_pc;
      branch_in = exp_br;
      #2;   // sample just before the next edge
      ex = (instr[1:0] != 2'b11) ? ref_expand(instr[15:0]) : {1'b0, instr};
      eff = ex[31:0];
      exp_c = ref_control(eff);
      if (ex[32]) begin
         exp_c = '0;
         exp_c.illegal = 1'b1;
      end
      if (must_be_illegal) begin
         expect_eq("illegal", 1'b1, control_signals.illegal);
      end
      expect_eq("rd", eff[11:7], reg_rd_id);
      expect_eq("read_data1", model_regs[eff[19:15]], read_data1);
      expect_eq("read_data2", model_regs[eff[24:20]], read_data2);
      if (exp_c.illegal) begin
         expect_eq("illegal_enables",
                   {1'b1, 5'b00000},
                   {control_signals.illegal, control_signals.reg_write, control_signals.mem_read,
                    control_signals.mem_write, control_signals.is_branch, control_signals.is_jump});
      end else begin
         expect_eq("control", exp_c, control_signals);
         expect_eq("immediate", ref_imm(eff, exp_c.encoding), immediate_data);
      end
      for (int r = 0; r < reg_count; r++) begin
         expect_eq("debug_reg", model_regs[r], debug_reg[r]);
      end
      checks++;
      pt_checks++;
      if (pc_out !== exp_pc || branch_out !== exp_br) begin
         errors++;
         pt_errs++;
         $display("ERR pass_through expected %h_%h actual %h_%h", exp_pc, exp_br, pc_out,
                  branch_out);
      end
      if (we && wid != 5'd0) model_regs[wid] = wdata;   // visible after the coming edge
   endtask

   task automatic drive_random_write(input logic [31:0] instr, input logic must_be_illegal);
      logic [31:0] r;
      r = $random(seed);
      drive_and_check(instr, r[0], r[5:1], $random(seed), must_be_illegal);
   endtask

   task automatic make_base(input int i, output logic [31:0] w);
      logic [6:0] ops [0:8];
      ops = '{op_lui, op_auipc, op_jal, op_jalr, op_branch, op_load, op_store, op_imm, op_reg};
      w = $random(seed);
      w[6:0] = ops[i % 9];   // every opcode in turn
      case (w[6:0])
         op_jalr: w[14:12] = 3'b000;
         op_branch: if (w[14:13] == 2'b01) w[14] = 1'b1;
         op_load, op_store: w[14:12] = 3'b010;
         op_imm: if (w[13:12] == 2'b01) w[31:25] = {1'b0, w[14] & w[30], 5'd0};
         op_reg: begin
            w[31:25] = {1'b0, w[30], 5'd0};
            if (w[30] && w[14:12] != 3'b101) w[14:12] = 3'b000;
         end
         default: ;
      endcase
   endtask

   task automatic make_comp(input int i, output logic [31:0] w);
      logic [4:0] kinds [0:9];
      kinds = '{5'b00_010, 5'b00_110, 5'b01_000, 5'b01_010, 5'b01_011,
                5'b01_101, 5'b01_110, 5'b01_111, 5'b10_100, 5'b10_100};
      w = $random(seed);
      w[1:0] = kinds[i % 10][4:3];
      w[15:13] = kinds[i % 10][2:0];
      if (i % 10 >= 8) w[12] = (i % 10 == 9);   // c.mv then c.add
   endtask

   task automatic make_bad(input int i, output logic [31:0] w);
      w = $random(seed);
      case (i % 8)
         0: w[6:0] = 7'b0001111;   // fence
         1: w[6:0] = 7'b1110011;   // system
         2: w = {w[31:15], 1'b1, w[13:12], w[11:7], op_load};
         3: w = {w[31:15], 1'b1, w[13:12], w[11:7], op_store};
         4: w = {w[31:15], 2'b01, w[12], w[11:7], op_branch};
         5: w = {7'b0000001, w[24:7], op_reg};   // m extension
         6: w[15:0] = {3'b001, w[12:2], 2'b01};   // c.jal, outside the subset
         default: w = '0;
      endcase
   endtask

   task automatic run_tests();
      logic [31:0] w;
      logic [4:0]  wid;
      logic [4:0]  rs1;
      logic [4:0]  last_wid;
      start_test("reset");
      drive_and_check(32'h0000_0013, 1'b0, 5'd0, '0, 1'b0);
      end_test();
      start_test("write_read");
      last_wid = 5'd1;
      for (int k = 0; k < 200; k++) begin
         w = $random(seed);
         wid = w[4:0];
         if (k % 8 == 0) wid = 5'd0;
         w = $random(seed);
         rs1 = w[4:0];
         if (k % 2 == 1) rs1 = last_wid;   // read back the previous write
         w = $random(seed);
         w = {7'd0, w[24:20], rs1, 3'b000, w[11:7], op_reg};
         drive_and_check(w, 1'b1, wid, $random(seed), 1'b0);
         last_wid = wid;
      end
      end_test();
      start_test("base_decode");
      for (int k = 0; k < 300; k++) begin
         make_base(k, w);
         drive_random_write(w, 1'b0);
      end
      end_test();
      start_test("compressed");
      for (int k = 0; k < 200; k++) begin
         make_comp(k, w);
         drive_random_write(w, 1'b0);
      end
      end_test();
      start_test("illegal");
      for (int k = 0; k < 80; k++) begin
         make_bad(k, w);
         drive_random_write(w, 1'b1);
      end
      end_test();
      $display("test pass_through: %0d checks, %0d errors", pt_checks, pt_errs);
   endtask

   initial begin : main_seq
      int wait_cycles;
      seed = 22466;
      instruction = 32'h0000_0013;
      pc = '0;
      branch_in = '0;
      write_en = 1'b0;
      write_id = 5'd0;
      write_data = '0;
      checks = 0;
      errors = 0;
      pt_checks = 0;
      pt_errs = 0;
      for (int r = 0; r < reg_count; r++) begin
         model_regs[r] = '0;
      end
      wait_cycles = 0;
      while (rst_n !== 1'b1 && wait_cycles < 40) begin
         @(posedge clk);
         wait_cycles++;
      end
      if (rst_n !== 1'b1) begin
         $display("reset was never released");
         errors++;
      end else begin
         run_tests();
      end
      $display("all tests: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== decode_stage.f ====
logic/rv_decode_pkg.sv
logic/rv_decompress.sv
logic/rv_register_file.sv
logic/rv_control_unit.sv
logic/decode_stage.sv
sim/decode_stage_sva.sv
sim/decode_stage_tb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - logic/rv_decode_pkg.sv
  - logic/rv_decompress.sv
  - logic/rv_register_file.sv
  - logic/rv_control_unit.sv
  - logic/decode_stage.sv
  - target: simulation
    files:
      - sim/decode_stage_sva.sv
      - sim/decode_stage_tb.sv
